// ==== compile.f ====
+incdir+hdl
hdl/memStagePkg.sv
hdl/dataCache.sv
hdl/memoryStage.sv
hdl/memController.sv
hdl/memSubsystem.sv
tests/memSubsystemTb.sv

// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# The binary exits non-zero on $fatal, so make fails with the simulation
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/memSubsystemTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "memStage_params.svh"

module memSubsystemTb;
    import memStagePkg::*;

    typedef enum logic {
        OpRead  = 1'b0,
        OpWrite = 1'b1
    } accessOp_e;

    // One stimulus row with its expected outcome
    // expEx is {memAccessEx, memWriteEx, fftNotCompleteEx}
    typedef struct packed {
        accessOp_e  op;
        word_t      addr;
        logic       fft;
        logic [2:0] expEx;
        logic       expHit;
    } entry_t;

    // Line 4, used for the plain hit checks
    localparam word_t AddrC = 32'h8000_0100;
    // Lines A and B share index 1 with tags 0 and 1
    localparam word_t AddrA = 32'h8000_0040;
    localparam word_t AddrB = 32'h8000_0240;
    // Odd parity in bits 29..28 puts both in the FFT buffer region
    localparam word_t AddrF = 32'h1000_0180;
    localparam word_t AddrG = 32'h2000_01C0;

    logic clk = 1'b0;
    logic rst;
    word_t aluResult;
    word_t read2Data;
    logic memRead;
    logic memWrite;
    logic fftCalculating;
    word_t memoryOut;
    logic stall;
    logic accessDone;
    logic memAccessEx;
    logic memWriteEx;
    logic fftNotCompleteEx;

    entry_t stimTable [$];
    // Word memory indexed by address bits 11..2
    word_t refMem [1024];
    int limitCycles = 0;
    logic tableBuilt = 1'b0;

    memSubsystem DUT (
        .clk(clk), .rst(rst),
        .aluResult(aluResult), .read2Data(read2Data),
        .memRead(memRead), .memWrite(memWrite), .fftCalculating(fftCalculating),
        .memoryOut(memoryOut), .stall(stall), .accessDone(accessDone),
        .memAccessEx(memAccessEx), .memWriteEx(memWriteEx),
        .fftNotCompleteEx(fftNotCompleteEx)
    );

    // 4 ns period
    always #2 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkWord(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("** Error (%0t): %s: got %h, expected %h", $time, what, got, exp);
            abortRun("word mismatch");
        end
    endtask

    task automatic checkFlags(input logic [2:0] got, input logic [2:0] exp, input string what);
        if (got !== exp) begin
            $display("** Error (%0t): %s: got %b, expected %b", $time, what, got, exp);
            abortRun("exception flag mismatch");
        end
    endtask

    task automatic checkLevel(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error (%0t): %s: got %b, expected %b", $time, what, got, exp);
            abortRun("control signal mismatch");
        end
    endtask

    task automatic checkLatency(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("** Error (%0t): %s: accessDone after %0d cycles, expected %0d",
                     $time, what, got, exp);
            abortRun("latency mismatch");
        end
    endtask

    function automatic void addEntry(input accessOp_e op, input word_t addr, input logic fft,
                                     input logic [2:0] expEx, input logic expHit);
        entry_t e;
        e.op = op;
        e.addr = addr;
        e.fft = fft;
        e.expEx = expEx;
        e.expHit = expHit;
        stimTable.push_back(e);
    endfunction

    function automatic void buildTable();
        // Cold miss, then hits on the filled line
        addEntry(OpRead, AddrC, 1'b0, 3'b000, 1'b0);
        addEntry(OpRead, AddrC + 32'd4, 1'b0, 3'b000, 1'b1);
        addEntry(OpWrite, AddrC + 32'd8, 1'b0, 3'b000, 1'b1);
        addEntry(OpRead, AddrC + 32'd8, 1'b0, 3'b000, 1'b1);
        // A and B fight over index 1
        // Each miss after a write evicts a dirty line
        addEntry(OpRead, AddrA, 1'b0, 3'b000, 1'b0);
        addEntry(OpWrite, AddrA, 1'b0, 3'b000, 1'b1);
        addEntry(OpWrite, AddrB, 1'b0, 3'b000, 1'b0);
        addEntry(OpRead, AddrA, 1'b0, 3'b000, 1'b0);
        addEntry(OpWrite, AddrA + 32'd4, 1'b0, 3'b000, 1'b1);
        addEntry(OpRead, AddrB, 1'b0, 3'b000, 1'b0);
        addEntry(OpWrite, AddrB + 32'd8, 1'b0, 3'b000, 1'b1);
        addEntry(OpRead, AddrA, 1'b0, 3'b000, 1'b0);
        addEntry(OpRead, AddrA + 32'd4, 1'b0, 3'b000, 1'b1);
        // Clean victim this time so B is simply refilled
        addEntry(OpRead, AddrB + 32'd8, 1'b0, 3'b000, 1'b0);
        // Top nibble of even parity is outside the data region
        addEntry(OpRead, 32'h0000_0080, 1'b0, 3'b100, 1'b0);
        addEntry(OpWrite, 32'h3000_0080, 1'b0, 3'b010, 1'b0);
        addEntry(OpRead, 32'hF000_0080, 1'b1, 3'b100, 1'b0);
        // FFT buffer is blocked while calculating and open once it is done
        addEntry(OpRead, AddrF, 1'b1, 3'b001, 1'b0);
        addEntry(OpRead, AddrF, 1'b0, 3'b000, 1'b0);
        addEntry(OpWrite, AddrG, 1'b1, 3'b001, 1'b0);
        addEntry(OpWrite, AddrG, 1'b0, 3'b000, 1'b0);
        addEntry(OpRead, AddrG, 1'b0, 3'b000, 1'b1);
        addEntry(OpRead, AddrF, 1'b0, 3'b000, 1'b1);
    endfunction

    // Drives one row, follows it to completion or rejection, then drops it
    task automatic runEntry(input entry_t e);
        int cycles;
        int refIdx;
        word_t storeData;
        refIdx = int'(e.addr[11:2]);
        storeData = '0;
        if (e.op == OpWrite) begin
            storeData = $urandom;
        end
        @(posedge clk);
        #1;
        aluResult = e.addr;
        read2Data = storeData;
        memRead = (e.op == OpRead);
        memWrite = (e.op == OpWrite);
        fftCalculating = e.fft;
        @(negedge clk);
        checkFlags({memAccessEx, memWriteEx, fftNotCompleteEx}, e.expEx, "exception flags");
        if (e.expEx != 3'b000) begin
            // Rejected request must leave the stage idle for as long as it is held
            checkLevel(stall, 1'b0, "stall on excepting request");
            checkLevel(accessDone, 1'b0, "accessDone on excepting request");
            @(negedge clk);
            checkLevel(stall, 1'b0, "stall one cycle after exception");
            checkLevel(accessDone, 1'b0, "accessDone one cycle after exception");
        end else begin
            // Request cycle counts as the first one
            cycles = 1;
            while (!accessDone) begin
                checkLevel(stall, 1'b1, "stall while access pending");
                checkWord(memoryOut, '0, "memoryOut before completion");
                @(negedge clk);
                cycles++;
            end
            checkLevel(stall, 1'b0, "stall in completion cycle");
            if (e.op == OpWrite) begin
                refMem[refIdx] = storeData;
                checkWord(memoryOut, '0, "memoryOut on write completion");
            end else begin
                checkWord(memoryOut, refMem[refIdx], "read data");
            end
            if (e.expHit) begin
                checkLatency(cycles, 2, "hit latency");
            end
        end
        @(posedge clk);
        #1;
        memRead = 1'b0;
        memWrite = 1'b0;
        fftCalculating = 1'b0;
        aluResult = '0;
        read2Data = '0;
        // accessDone is a single cycle pulse
        @(negedge clk);
        checkLevel(accessDone, 1'b0, "accessDone after request dropped");
        checkWord(memoryOut, '0, "memoryOut while idle");
    endtask

    initial begin
        void'($urandom(32'h4e0b));
        rst = 1'b1;
        aluResult = '0;
        read2Data = '0;
        memRead = 1'b0;
        memWrite = 1'b0;
        fftCalculating = 1'b0;
        foreach (refMem[i]) begin
            refMem[i] = '0;
        end
        buildTable();
        // Worst case per row covers evict, fill and retry with margin
        limitCycles = stimTable.size() * 4 * (`MC_LATENCY + 8) + 50;
        tableBuilt = 1'b1;

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        checkLevel(stall, 1'b0, "stall after reset");
        checkLevel(accessDone, 1'b0, "accessDone after reset");
        checkWord(memoryOut, '0, "memoryOut after reset");

        foreach (stimTable[i]) begin
            runEntry(stimTable[i]);
        end

        $display("Simulation finished: PASS");
        $finish;
    end

    // Ends a run whose accesses never complete
    initial begin
        wait (tableBuilt);
        repeat (limitCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles with accesses still pending", limitCycles);
        abortRun("watchdog timeout");
    end

endmodule

`default_nettype wire

// ==== hdl/memSubsystem.sv ====
`timescale 1ns/10ps
`default_nettype none

module memSubsystem (
    input  logic               clk,
    input  logic               rst,
    input  memStagePkg::word_t aluResult,
    input  memStagePkg::word_t read2Data,
    input  logic               memRead,
    input  logic               memWrite,
    input  logic               fftCalculating,
    output memStagePkg::word_t memoryOut,
    output logic               stall,
    output logic               accessDone,
    output logic               memAccessEx,
    output logic               memWriteEx,
    output logic               fftNotCompleteEx
);
    import memStagePkg::*;

    // Stage to controller
    logic mcMiss;
    logic mcEvict;
    lineAddr_t mcAddr;
    block_t mcDataOut;
    // Controller to stage
    logic mcDataValid;
    logic evictDone;
    block_t mcDataIn;

    // Stage to cache
    logic cacheEnable;
    logic cacheRead;
    logic cacheWrite;
    logic cacheLoad;
    word_t cacheAddr;
    word_t cacheDataIn;
    block_t cacheBlkIn;
    // Cache to stage
    logic cacheHit;
    logic cacheMiss;
    logic cacheDirtyEvict;
    word_t cacheDataOut;
    block_t cacheBlkOut;
    lineAddr_t cacheVictimAddr;

    memoryStage iMemoryStage (
        .clk(clk), .rst(rst),
        .aluResult(aluResult), .read2Data(read2Data),
        .memRead(memRead), .memWrite(memWrite), .fftCalculating(fftCalculating),
        .mcDataValid(mcDataValid), .evictDone(evictDone), .mcDataIn(mcDataIn),
        .cacheHit(cacheHit), .cacheMiss(cacheMiss), .cacheDirtyEvict(cacheDirtyEvict),
        .cacheDataOut(cacheDataOut), .cacheBlkOut(cacheBlkOut),
        .cacheVictimAddr(cacheVictimAddr),
        .memoryOut(memoryOut), .stall(stall), .accessDone(accessDone),
        .memAccessEx(memAccessEx), .memWriteEx(memWriteEx),
        .fftNotCompleteEx(fftNotCompleteEx),
        .mcMiss(mcMiss), .mcEvict(mcEvict), .mcAddr(mcAddr), .mcDataOut(mcDataOut),
        .cacheEnable(cacheEnable), .cacheRead(cacheRead), .cacheWrite(cacheWrite),
        .cacheLoad(cacheLoad), .cacheAddr(cacheAddr), .cacheDataIn(cacheDataIn),
        .cacheBlkIn(cacheBlkIn)
    );

    dataCache iDataCache (
        .clk(clk), .rst(rst),
        .en(cacheEnable), .rd(cacheRead), .wr(cacheWrite), .ld(cacheLoad),
        .addr(cacheAddr), .dataIn(cacheDataIn), .blkIn(cacheBlkIn),
        .hit(cacheHit), .miss(cacheMiss), .evict(cacheDirtyEvict),
        .dataOut(cacheDataOut), .blkOut(cacheBlkOut), .victimAddr(cacheVictimAddr)
    );

    memController iMemController (
        .clk(clk), .rst(rst),
        .miss(mcMiss), .evict(mcEvict), .addr(mcAddr), .dataIn(mcDataOut),
        .dataOut(mcDataIn), .dataValid(mcDataValid), .evictDone(evictDone)
    );

endmodule

`default_nettype wire

// ==== hdl/memController.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "memStage_params.svh"

module memController (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   miss,
    input  logic                   evict,
    input  memStagePkg::lineAddr_t addr,
    input  memStagePkg::block_t    dataIn,
    output memStagePkg::block_t    dataOut,
    output logic                   dataValid,
    output logic                   evictDone
);
    import memStagePkg::*;

    localparam int CntBits = $clog2(`MC_LATENCY + 1);

    mcState_e state;
    mcState_e nextState;

    // Cycles spent on the current request
    logic [CntBits-1:0] latCnt;
    // Set for a fill, clear for an eviction
    logic fillOp;
    // Response already given, waiting for the request to drop
    logic responded;
    lineAddr_t reqAddr;

    // Backing store, unwritten lines read as zero
    block_t store [`MC_LINES];
    logic [`MC_LINES-1:0] lineWritten;

    logic respPulse;
    logic reqHeld;

    assign respPulse = (state == MC_RESPOND) && !responded;
    assign reqHeld = fillOp ? miss : evict;

    assign dataValid = respPulse && fillOp;
    assign evictDone = respPulse && !fillOp;
    assign dataOut = (dataValid && lineWritten[reqAddr]) ? store[reqAddr] : '0;

    always_comb begin
        nextState = state;
        case (state)
            MC_IDLE: begin
                // Eviction wins if both are raised
                if (evict) begin
                    nextState = MC_EVICT;
                end else if (miss) begin
                    nextState = MC_FILL;
                end
            end
            MC_EVICT, MC_FILL: begin
                if (latCnt == CntBits'(`MC_LATENCY - 1)) begin
                    nextState = MC_RESPOND;
                end
            end
            MC_RESPOND: begin
                if (responded && !reqHeld) begin
                    nextState = MC_IDLE;
                end
            end
            default: begin
                nextState = MC_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= MC_IDLE;
            latCnt <= '0;
            fillOp <= 1'b0;
            responded <= 1'b0;
            lineWritten <= '0;
        end else begin
            state <= nextState;
            case (state)
                MC_IDLE: begin
                    latCnt <= CntBits'(1);
                    responded <= 1'b0;
                    if (evict) begin
                        fillOp <= 1'b0;
                    end else if (miss) begin
                        fillOp <= 1'b1;
                    end
                end
                MC_EVICT, MC_FILL: begin
                    latCnt <= latCnt + CntBits'(1);
                end
                default: begin
                    responded <= 1'b1;
                    if (evictDone) begin
                        lineWritten[reqAddr] <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Request line and store contents
    always_ff @(posedge clk) begin
        if (state == MC_IDLE) begin
            reqAddr <= addr;
        end
        if (evictDone) begin
            store[reqAddr] <= dataIn;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/memoryStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module memoryStage (
    input  logic                   clk,
    input  logic                   rst,
    input  memStagePkg::word_t     aluResult,
    input  memStagePkg::word_t     read2Data,
    input  logic                   memRead,
    input  logic                   memWrite,
    input  logic                   fftCalculating,
    input  logic                   mcDataValid,
    input  logic                   evictDone,
    input  memStagePkg::block_t    mcDataIn,
    input  logic                   cacheHit,
    input  logic                   cacheMiss,
    input  logic                   cacheDirtyEvict,
    input  memStagePkg::word_t     cacheDataOut,
    input  memStagePkg::block_t    cacheBlkOut,
    input  memStagePkg::lineAddr_t cacheVictimAddr,
    output memStagePkg::word_t     memoryOut,
    output logic                   stall,
    output logic                   accessDone,
    output logic                   memAccessEx,
    output logic                   memWriteEx,
    output logic                   fftNotCompleteEx,
    output logic                   mcMiss,
    output logic                   mcEvict,
    output memStagePkg::lineAddr_t mcAddr,
    output memStagePkg::block_t    mcDataOut,
    output logic                   cacheEnable,
    output logic                   cacheRead,
    output logic                   cacheWrite,
    output logic                   cacheLoad,
    output memStagePkg::word_t     cacheAddr,
    output memStagePkg::word_t     cacheDataIn,
    output memStagePkg::block_t    cacheBlkIn
);
    import memStagePkg::*;

    stageState_e currState;
    stageState_e nextState;

    // Line the pipeline is asking for
    lineAddr_t reqLine;
    // Any exception blocks the start of an access
    logic anyEx;

    assign reqLine = aluResult[11:6];

    // Data region needs odd parity in the top nibble
    assign memAccessEx = memRead && !(^aluResult[31:28]);
    assign memWriteEx = memWrite && !(^aluResult[31:28]);

    // FFT buffer region is off limits while the accelerator runs
    assign fftNotCompleteEx = fftCalculating && (^aluResult[29:28]) && (memRead || memWrite);

    assign anyEx = memAccessEx || memWriteEx || fftNotCompleteEx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            currState <= IDLE;
        end else begin
            currState <= nextState;
        end
    end

    always_comb begin
        nextState = currState;
        memoryOut = '0;
        stall = 1'b0;
        accessDone = 1'b0;
        mcMiss = 1'b0;
        mcEvict = 1'b0;
        mcAddr = reqLine;
        mcDataOut = '0;
        cacheEnable = 1'b0;
        cacheRead = 1'b0;
        cacheWrite = 1'b0;
        cacheLoad = 1'b0;
        cacheAddr = aluResult;
        cacheDataIn = '0;
        cacheBlkIn = '0;

        case (currState)
            IDLE: begin
                // Excepting requests never leave IDLE
                stall = (memRead || memWrite) && !anyEx;
                if (memRead && !anyEx) begin
                    nextState = READ;
                end else if (memWrite && !anyEx) begin
                    nextState = WRITE;
                end
            end
            READ, WRITE: begin
                cacheEnable = 1'b1;
                cacheRead = (currState == READ);
                cacheWrite = (currState == WRITE);
                cacheDataIn = read2Data;
                if (cacheHit) begin
                    accessDone = 1'b1;
                    memoryOut = cacheDataOut;
                    nextState = IDLE;
                end else begin
                    stall = 1'b1;
                    // Dirty victim goes first, the fill waits for its turn
                    mcEvict = cacheDirtyEvict;
                    mcMiss = cacheMiss && !cacheDirtyEvict;
                    if (cacheDirtyEvict) begin
                        mcAddr = cacheVictimAddr;
                        mcDataOut = cacheBlkOut;
                        nextState = (currState == READ) ? EVICT_RD : EVICT_WR;
                    end else begin
                        nextState = (currState == READ) ? LOAD_RD : LOAD_WR;
                    end
                end
            end
            EVICT_RD, EVICT_WR: begin
                stall = 1'b1;
                cacheEnable = 1'b1;
                // Hold victim line and data until the controller takes them
                mcEvict = 1'b1;
                mcAddr = cacheVictimAddr;
                mcDataOut = cacheBlkOut;
                if (evictDone) begin
                    nextState = (currState == EVICT_RD) ? LOAD_RD : LOAD_WR;
                end
            end
            LOAD_RD, LOAD_WR: begin
                stall = 1'b1;
                cacheEnable = 1'b1;
                mcMiss = 1'b1;
                // Block is only valid in the response cycle
                cacheLoad = mcDataValid;
                cacheBlkIn = mcDataIn;
                if (mcDataValid) begin
                    nextState = (currState == LOAD_RD) ? WAIT_RD : WAIT_WR;
                end
            end
            WAIT_RD: begin
                stall = 1'b1;
                nextState = READ;
            end
            WAIT_WR: begin
                stall = 1'b1;
                nextState = WRITE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/dataCache.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "memStage_params.svh"

module dataCache (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en,
    input  logic                  rd,
    input  logic                  wr,
    input  logic                  ld,
    input  memStagePkg::word_t    addr,
    input  memStagePkg::word_t    dataIn,
    input  memStagePkg::block_t   blkIn,
    output logic                  hit,
    output logic                  miss,
    output logic                  evict,
    output memStagePkg::word_t    dataOut,
    output memStagePkg::block_t   blkOut,
    output memStagePkg::lineAddr_t victimAddr
);
    import memStagePkg::*;

    // Tag is whatever the index leaves of the line address
    localparam int TagBits = $bits(lineAddr_t) - `DCACHE_INDEX_BITS;
    localparam int WordSelBits = $clog2(BlockWords);

    // Line storage
    block_t lineData [`DCACHE_LINES];
    logic [TagBits-1:0] lineTag [`DCACHE_LINES];

    // Per-line status
    logic [`DCACHE_LINES-1:0] lineValid;
    logic [`DCACHE_LINES-1:0] lineDirty;

    // Address fields
    lineAddr_t reqLine;
    logic [`DCACHE_INDEX_BITS-1:0] index;
    logic [TagBits-1:0] reqTag;
    logic [WordSelBits-1:0] wordSel;

    // Lookup terms
    logic access;
    logic tagMatch;

    assign reqLine = addr[11:6];
    assign index = reqLine[`DCACHE_INDEX_BITS-1:0];
    assign reqTag = reqLine[$bits(lineAddr_t)-1:`DCACHE_INDEX_BITS];
    assign wordSel = addr[5:2];

    // Only word reads and writes count as lookups
    assign access = en && (rd || wr);
    assign tagMatch = lineValid[index] && (lineTag[index] == reqTag);

    assign hit = access && tagMatch;
    assign miss = access && !tagMatch;

    // Dirty victim has to go back to memory before the fill
    assign evict = miss && lineValid[index] && lineDirty[index];

    // Read data is zero unless a read hits
    assign dataOut = (hit && rd) ? lineData[index][wordSel] : '0;

    // Victim view of the indexed line
    assign blkOut = lineData[index];
    assign victimAddr = {lineTag[index], index};

    // Status bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lineValid <= '0;
            lineDirty <= '0;
        end else if (en) begin
            if (ld) begin
                // Fresh fill matches memory
                lineValid[index] <= 1'b1;
                lineDirty[index] <= 1'b0;
            end else if (wr && hit) begin
                lineDirty[index] <= 1'b1;
            end
        end
    end

    // Data and tag arrays
    always_ff @(posedge clk) begin
        if (en) begin
            if (ld) begin
                lineData[index] <= blkIn;
                lineTag[index] <= reqTag;
            end else if (wr && hit) begin
                // Single word update within the line
                lineData[index][wordSel] <= dataIn;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/memStagePkg.sv ====
`default_nettype none

package memStagePkg;

    // Words per cache block
    localparam int BlockWords = 16;

    // Data and address word
    typedef logic [31:0] word_t;

    // One cache line, word 0 in the low bits
    typedef logic [BlockWords-1:0][31:0] block_t;

    // Line address taken from address bits 11..6
    // Low bits are the cache index, high bits the tag
    typedef logic [5:0] lineAddr_t;

    // Memory stage sequencing
    typedef enum logic [3:0] {
        IDLE     = 4'd0,
        READ     = 4'd1,
        EVICT_RD = 4'd2,
        LOAD_RD  = 4'd3,
        WAIT_RD  = 4'd4,
        WRITE    = 4'd5,
        EVICT_WR = 4'd6,
        LOAD_WR  = 4'd7,
        WAIT_WR  = 4'd8
    } stageState_e;

    // Memory controller sequencing
    typedef enum logic [1:0] {
        MC_IDLE    = 2'd0,
        MC_EVICT   = 2'd1,
        MC_FILL    = 2'd2,
        MC_RESPOND = 2'd3
    } mcState_e;

endpackage

`default_nettype wire

// ==== hdl/memStage_params.svh ====
`ifndef MEMSTAGE_PARAMS_SVH
`define MEMSTAGE_PARAMS_SVH

// Data cache geometry
// Direct mapped, one 512-bit block per line
`define DCACHE_LINES 8

// Index width must match log2 of the line count
// Remaining line address bits form the tag
`define DCACHE_INDEX_BITS 3

// Backing store geometry
// One entry per 6-bit line address
`define MC_LINES 64

// Controller response latency in cycles
// Counted from the cycle the request is first seen
`define MC_LATENCY 4

`endif
